/* vlog.f */
+incdir+include
design/uart_dma_pkg.sv
design/rx_deserializer.sv
design/rx_fifo.sv
design/rx_manager.sv
design/rx_csr.sv
design/uart_dma_rx.sv
verification/uart_dma_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary -f vlog.f --top-module uart_dma_rx_tb -Mdir obj_dir -o uart_dma_rx_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/uart_dma_rx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1

/* verification/uart_dma_rx_tb.sv */
`timescale 1ns/1ps
`include "uart_dma_defines.svh"

module uart_dma_rx_tb;

    localparam int FRAMES = 40 + 20 + 12 + 1 + 3; // frames sent over all tests.

    logic        clk = 1'b0;
    logic        ptr_rst = 1'b1;
    logic        rx = 1'b1;
    logic [31:0] awaddr = '0;
    logic        awvalid = 1'b0;
    logic        awready;
    logic [31:0] wdata = '0;
    logic [3:0]  wstrb = '0;
    logic        wvalid = 1'b0;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready = 1'b0;
    logic [31:0] araddr = '0;
    logic        arvalid = 1'b0;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready = 1'b0;
    logic        mem_req;
    logic        mem_ready = 1'b0;
    logic [31:0] mem_addr;
    logic [7:0]  mem_data;

    logic [31:0] lfsr_state = 32'h1ba5_84e9;
    int          errors = 0;
    int          div = 1;
    int          watch_ns = 0;
    string       test_name = "reset";
    logic [7:0]  exp_q [$];
    logic [7:0]  mem_model [logic [31:0]];
    logic [7:0]  sent [40];
    logic [31:0] model_ptr = '0;
    int          store_count = 0;
    logic        hold_ready = 1'b0;
    logic        ready_next = 1'b0;
    logic        stall_armed = 1'b0;
    logic [2:0]  stall_left = '0;
    logic        req_seen = 1'b0;

    uart_dma_rx uart_dma_rx_i (
        .clk(clk), .ptr_rst(ptr_rst), .rx(rx),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .mem_req(mem_req), .mem_ready(mem_ready), .mem_addr(mem_addr), .mem_data(mem_data)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? 32'hD000_0001 : 32'h0);
            r = {r[30:0], b};
        end
        return r;
    endfunction

    task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        check("write ready", 32'd1, 32'(wready)); // both ready signals rise together.
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        check("write response", 32'd0, 32'(bresp));
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] value);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        value = rdata;
        check("read response", 32'd0, 32'(rresp));
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic set_buffer(input logic [31:0] first, input logic [31:0] last);
        axi_write(`UART_DMA_REG_BUF_START, first);
        axi_write(`UART_DMA_REG_BUF_END, last);
        axi_write(`UART_DMA_REG_CTRL, 32'h3); // enable and reload the pointer.
        model_ptr = first;
    endtask

    // start bit, eight data bits lsb first, stop bit, then one idle bit.
    task automatic send_frame(input logic [7:0] b, input logic stop);
        logic [9:0] bits;
        bits = {stop, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = bits[i];
            repeat (`UART_DMA_OVERSAMPLE * (div + 1)) @(posedge clk);
            #2;
        end
        rx = 1'b1;
        repeat (`UART_DMA_OVERSAMPLE * (div + 1)) @(posedge clk);
        #2;
    endtask

    task automatic wait_stores(input int target);
        int n;
        n = 0;
        while (store_count < target && n < 2000) begin
            @(posedge clk);
            #2;
            n++;
        end
        check("store count", 32'(target), 32'(store_count));
    endtask

    // memory model and scoreboard; a store completes on the edge after this sample.
    always @(negedge clk) begin
        ready_next = 1'b0;
        if (mem_req) req_seen = 1'b1;
        if (mem_req && mem_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected store of %h at address %h in %s", mem_data, mem_addr,
                         test_name);
            end else begin
                check("store data", {24'h0, exp_q.pop_front()}, {24'h0, mem_data});
            end
            check("store address", model_ptr, mem_addr);
            mem_model[mem_addr] = mem_data;
            model_ptr = model_ptr + 32'd1;
            store_count++;
            stall_armed = 1'b0;
        end else if (mem_req && !hold_ready) begin
            if (!stall_armed) begin
                stall_left  = 3'(random_bits(3));
                stall_armed = 1'b1;
            end
            if (stall_left == 3'd0) ready_next = 1'b1;
            else stall_left = stall_left - 3'd1;
        end else if (!mem_req) begin
            stall_armed = 1'b0;
        end
    end

    always @(posedge clk) begin
        #2;
        mem_ready = ready_next;
    end

    initial begin
        wait (watch_ns > 0);
        #(watch_ns);
        $display("timeout: the DUT did not finish within %0d ns", watch_ns);
        $display("errors: %0d", errors);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [7:0]  b;
        int          base;
        logic [31:0] ptr_before;
        div = 1 + int'(random_bits(8) % 3);
        watch_ns = 2 * FRAMES * 11 * `UART_DMA_OVERSAMPLE * (div + 1) * 20;
        repeat (3) @(posedge clk);
        #2;
        ptr_rst = 1'b0;

        test_name = "register readback";
        axi_write(`UART_DMA_REG_BAUD, 32'(div));
        set_buffer(32'h0000_1000, 32'h0000_1100);
        axi_read(`UART_DMA_REG_BAUD, rd);
        check("baud", 32'(div), rd);
        axi_read(`UART_DMA_REG_BUF_START, rd);
        check("buffer start", 32'h0000_1000, rd);
        axi_read(`UART_DMA_REG_BUF_END, rd);
        check("buffer end", 32'h0000_1100, rd);
        axi_read(`UART_DMA_REG_PTR, rd);
        check("pointer", 32'h0000_1000, rd);

        test_name = "ordered dma";
        base = store_count;
        for (int i = 0; i < 40; i++) begin
            b = 8'(random_bits(8));
            sent[i] = b;
            exp_q.push_back(b);
            send_frame(b, 1'b1);
        end
        wait_stores(base + 40);
        for (int i = 0; i < 40; i++) begin
            check("memory byte", {24'h0, sent[i]}, {24'h0, mem_model[32'h1000 + 32'(i)]});
        end
        axi_read(`UART_DMA_REG_PTR, rd);
        check("pointer", 32'h0000_1028, rd);

        test_name = "buffer full";
        set_buffer(32'h0000_2000, 32'h0000_2010);
        base = store_count;
        for (int i = 0; i < 20; i++) begin
            b = 8'(random_bits(8));
            exp_q.push_back(b);
            send_frame(b, 1'b1);
        end
        wait_stores(base + 16);
        idle_cycles(100);
        check("stores before reload", 32'(base + 16), 32'(store_count));
        axi_read(`UART_DMA_REG_STATUS, rd);
        check("full flag", 32'd1, 32'(rd[0]));
        set_buffer(32'h0000_2000, 32'h0000_2010); // the last four bytes restart at the start.
        wait_stores(base + 20);

        test_name = "overflow";
        set_buffer(32'h0000_3000, 32'h0000_3100);
        base = store_count;
        hold_ready = 1'b1;
        for (int i = 0; i < 12; i++) begin
            b = 8'(random_bits(8));
            // one byte waits in the writer and the FIFO holds the next ones.
            if (i < `UART_DMA_FIFO_DEPTH + 1) exp_q.push_back(b);
            send_frame(b, 1'b1);
        end
        axi_read(`UART_DMA_REG_STATUS, rd);
        check("overflow flag", 32'd1, 32'(rd[1]));
        hold_ready = 1'b0;
        wait_stores(base + `UART_DMA_FIFO_DEPTH + 1);
        idle_cycles(100);
        check("stores after overflow", 32'(base + `UART_DMA_FIFO_DEPTH + 1), 32'(store_count));
        axi_write(`UART_DMA_REG_STATUS, 32'h2);
        axi_read(`UART_DMA_REG_STATUS, rd);
        check("overflow cleared", 32'd0, 32'(rd[1]));

        test_name = "framing error";
        base = store_count;
        send_frame(8'(random_bits(8)), 1'b0);
        idle_cycles(20);
        axi_read(`UART_DMA_REG_STATUS, rd);
        check("framing flag", 32'd1, 32'(rd[2]));
        check("stores", 32'(base), 32'(store_count));

        test_name = "disable";
        axi_write(`UART_DMA_REG_CTRL, 32'h0);
        base = store_count;
        ptr_before = model_ptr;
        req_seen = 1'b0;
        for (int i = 0; i < 3; i++) begin
            send_frame(8'(random_bits(8)), 1'b1);
        end
        idle_cycles(20);
        check("memory request", 32'd0, 32'(req_seen));
        check("stores", 32'(base), 32'(store_count));
        axi_read(`UART_DMA_REG_PTR, rd);
        check("pointer", ptr_before, rd);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* design/uart_dma_rx.sv */
`timescale 1ns/1ps
`include "uart_dma_defines.svh"

module uart_dma_rx (
    input  logic                     clk,
    input  logic                     ptr_rst,
    input  logic                     rx,
    input  logic [`UART_DMA_AW-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`UART_DMA_DW-1:0]   wdata,
    input  logic [`UART_DMA_DW/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [`UART_DMA_AW-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [`UART_DMA_DW-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    output logic                     mem_req,
    input  logic                     mem_ready,
    output logic [`UART_DMA_AW-1:0]   mem_addr,
    output logic [7:0]               mem_data
);
    logic                   en;
    logic [15:0]            baud_div;
    logic [`UART_DMA_AW-1:0] buf_start;
    logic [`UART_DMA_AW-1:0] buf_end;
    logic                   ptr_reload;
    logic [`UART_DMA_AW-1:0] ptr;
    logic                   dma_buf_full;
    logic                   overflow;
    logic                   frame_err;
    logic [7:0]             rx_data;
    logic                   byte_valid;
    logic                   fifo_write_en;
    logic                   fifo_read_en;
    logic [7:0]             fifo_data;
    logic                   fifo_full;
    logic                   fifo_empty;

    assign fifo_write_en = byte_valid && !fifo_full;
    assign overflow      = byte_valid && fifo_full; // the byte is dropped.

    rx_csr rx_csr_i (
        .clk(clk), .ptr_rst(ptr_rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .en(en), .baud_div(baud_div), .buf_start(buf_start), .buf_end(buf_end),
        .ptr_reload(ptr_reload), .ptr(ptr), .dma_buf_full(dma_buf_full),
        .overflow(overflow), .frame_err(frame_err)
    );

    rx_deserializer rx_deserializer_i (
        .clk(clk), .ptr_rst(ptr_rst), .en(en), .baud_div(baud_div), .rx(rx),
        .rx_data(rx_data), .byte_valid(byte_valid), .frame_err(frame_err)
    );

    rx_fifo rx_fifo_i (
        .clk(clk), .ptr_rst(ptr_rst), .flush(!en),
        .write_en(fifo_write_en), .data_in(rx_data),
        .read_en(fifo_read_en), .data_out(fifo_data),
        .full(fifo_full), .empty(fifo_empty)
    );

    rx_manager rx_manager_i (
        .clk(clk), .ptr_rst(ptr_rst), .en(en), .ptr_reload(ptr_reload),
        .buf_start(buf_start), .buf_end(buf_end),
        .fifo_empty(fifo_empty), .fifo_data(fifo_data), .fifo_read_en(fifo_read_en),
        .ptr(ptr), .dma_buf_full(dma_buf_full),
        .mem_req(mem_req), .mem_ready(mem_ready), .mem_addr(mem_addr), .mem_data(mem_data)
    );

endmodule

/* design/rx_csr.sv */
`timescale 1ns/1ps
`include "uart_dma_defines.svh"

module rx_csr (
    input  logic                     clk,
    input  logic                     ptr_rst,
    input  logic [`UART_DMA_AW-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`UART_DMA_DW-1:0]   wdata,
    input  logic [`UART_DMA_DW/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [`UART_DMA_AW-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [`UART_DMA_DW-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    output logic                     en,
    output logic [15:0]              baud_div,
    output logic [`UART_DMA_AW-1:0]   buf_start,
    output logic [`UART_DMA_AW-1:0]   buf_end,
    output logic                     ptr_reload,
    input  logic [`UART_DMA_AW-1:0]   ptr,
    input  logic                     dma_buf_full,
    input  logic                     overflow,
    input  logic                     frame_err
);
    import uart_dma_pkg::*;

    localparam int AW = `UART_DMA_AW;
    localparam int DW = `UART_DMA_DW;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic          aw_w_ready;
    logic          wr_fire;
    logic          rd_fire;
    logic          status_wr;
    reg_sel_t      wr_sel;
    reg_sel_t      rd_sel;
    logic [DW-1:0] wmask;
    logic [DW-1:0] rd_value;
    logic          ovf_flag;
    logic          ferr_flag;

    function automatic reg_sel_t decode(input logic [AW-1:0] addr);
        case (addr)
            `UART_DMA_REG_CTRL:      return SEL_CTRL;
            `UART_DMA_REG_BAUD:      return SEL_BAUD;
            `UART_DMA_REG_BUF_START: return SEL_BUF_START;
            `UART_DMA_REG_BUF_END:   return SEL_BUF_END;
            `UART_DMA_REG_PTR:       return SEL_PTR;
            `UART_DMA_REG_STATUS:    return SEL_STATUS;
            default:                 return SEL_NONE;
        endcase
    endfunction

    function automatic logic [DW-1:0] strb_mask(input logic [DW/8-1:0] strb);
        logic [DW-1:0] mask;
        for (int i = 0; i < DW / 8; i++) begin
            mask[i*8 +: 8] = {8{strb[i]}};
        end
        return mask;
    endfunction

    assign awready   = aw_w_ready;
    assign wready    = aw_w_ready;
    assign bresp     = RESP_OKAY;
    assign rresp     = RESP_OKAY;
    assign wr_fire   = aw_w_ready && awvalid && wvalid;
    assign rd_fire   = arready && arvalid;
    assign wr_sel    = decode(awaddr);
    assign rd_sel    = decode(araddr);
    assign wmask     = strb_mask(wstrb);
    assign status_wr = wr_fire && (wr_sel == SEL_STATUS) && wstrb[0];

    always_ff @(posedge clk) begin
        if (ptr_rst) begin
            aw_w_ready <= 1'b0;
            bvalid     <= 1'b0;
            arready    <= 1'b0;
            rvalid     <= 1'b0;
        end else begin
            aw_w_ready <= awvalid && wvalid && !aw_w_ready && !bvalid;
            if (wr_fire) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            arready <= arvalid && !arready && !rvalid;
            if (rd_fire) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ptr_rst) begin
            en         <= 1'b0;
            baud_div   <= '0;
            buf_start  <= '0;
            buf_end    <= '0;
            ptr_reload <= 1'b0;
            ovf_flag   <= 1'b0;
            ferr_flag  <= 1'b0;
        end else begin
            ptr_reload <= 1'b0;
            if (wr_fire) begin
                case (wr_sel)
                    SEL_CTRL: begin
                        if (wstrb[0]) begin
                            en         <= wdata[0];
                            ptr_reload <= wdata[1]; // bit 1 is a command and reads as zero.
                        end
                    end
                    SEL_BAUD: baud_div <= (baud_div & ~wmask[15:0]) | (wdata[15:0] & wmask[15:0]);
                    SEL_BUF_START: begin
                        buf_start <= (buf_start & ~wmask[AW-1:0]) | (wdata[AW-1:0] & wmask[AW-1:0]);
                    end
                    SEL_BUF_END: begin
                        buf_end <= (buf_end & ~wmask[AW-1:0]) | (wdata[AW-1:0] & wmask[AW-1:0]);
                    end
                    default: ;
                endcase
            end
            // a new event wins over a clear in the same cycle.
            ovf_flag  <= overflow || (ovf_flag && !(status_wr && wdata[1]));
            ferr_flag <= frame_err || (ferr_flag && !(status_wr && wdata[2]));
        end
    end

    always_comb begin
        case (rd_sel)
            SEL_CTRL:      rd_value = {{(DW-1){1'b0}}, en};
            SEL_BAUD:      rd_value = {{(DW-16){1'b0}}, baud_div};
            SEL_BUF_START: rd_value = DW'(buf_start);
            SEL_BUF_END:   rd_value = DW'(buf_end);
            SEL_PTR:       rd_value = DW'(ptr);
            SEL_STATUS:    rd_value = {{(DW-3){1'b0}}, ferr_flag, ovf_flag, dma_buf_full};
            default:       rd_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_fire) rdata <= rd_value;
    end

endmodule

/* design/rx_manager.sv */
`timescale 1ns/1ps
`include "uart_dma_defines.svh"

module rx_manager (
    input  logic                   clk,
    input  logic                   ptr_rst,
    input  logic                   en,
    input  logic                   ptr_reload,
    input  logic [`UART_DMA_AW-1:0] buf_start,
    input  logic [`UART_DMA_AW-1:0] buf_end,
    input  logic                   fifo_empty,
    input  logic [7:0]             fifo_data,
    output logic                   fifo_read_en,
    output logic [`UART_DMA_AW-1:0] ptr,
    output logic                   dma_buf_full,
    output logic                   mem_req,
    input  logic                   mem_ready,
    output logic [`UART_DMA_AW-1:0] mem_addr,
    output logic [7:0]             mem_data
);
    import uart_dma_pkg::*;

    dma_state_t state;
    logic       should_req;
    logic [7:0] data_reg;

    assign dma_buf_full = en && (ptr == buf_end);
    assign should_req   = en && !fifo_empty && !dma_buf_full;

    assign fifo_read_en = (state == DMA_IDLE) && should_req;
    assign mem_req      = en && (state == DMA_MEM_WAITING);
    assign mem_addr     = ptr;
    assign mem_data     = data_reg;

    always_ff @(posedge clk) begin
        if (ptr_rst) begin
            state <= DMA_IDLE;
            ptr   <= '0;
        end else if (ptr_reload) begin
            state <= DMA_IDLE; // a reload abandons any store in flight.
            ptr   <= buf_start;
        end else if (!en) begin
            state <= DMA_IDLE;
        end else begin
            case (state)
                DMA_IDLE: begin
                    if (should_req) state <= DMA_DATA_READY;
                end
                DMA_DATA_READY: begin
                    state <= DMA_MEM_WAITING;
                end
                DMA_MEM_WAITING: begin
                    if (mem_ready) state <= DMA_MEM_DONE;
                end
                DMA_MEM_DONE: begin
                    state <= DMA_IDLE;
                    ptr   <= ptr + 1'b1;
                end
                default: state <= DMA_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DMA_DATA_READY) data_reg <= fifo_data; // fifo output is valid here.
    end

endmodule

/* design/rx_fifo.sv */
`timescale 1ns/1ps
`include "uart_dma_defines.svh"

module rx_fifo (
    input  logic       clk,
    input  logic       ptr_rst,
    input  logic       flush,
    input  logic       write_en,
    input  logic [7:0] data_in,
    input  logic       read_en,
    output logic [7:0] data_out,
    output logic       full,
    output logic       empty
);
    localparam int DEPTH = `UART_DMA_FIFO_DEPTH;
    localparam int PW = $clog2(DEPTH);

    logic [7:0] mem [DEPTH];
    logic [PW:0] wr_ptr;
    logic [PW:0] rd_ptr;
    logic        do_write;
    logic        do_read;

    assign do_write = write_en && !full;
    assign do_read  = read_en && !empty;

    // the extra pointer bit tells a full buffer from an empty one.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PW] != rd_ptr[PW]) && (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]);

    always_ff @(posedge clk) begin
        if (ptr_rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) wr_ptr <= wr_ptr + 1'b1;
            if (do_read) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) mem[wr_ptr[PW-1:0]] <= data_in;
        if (do_read) data_out <= mem[rd_ptr[PW-1:0]]; // valid the cycle after read_en.
    end

endmodule

/* design/rx_deserializer.sv */
`timescale 1ns/1ps
`include "uart_dma_defines.svh"

module rx_deserializer (
    input  logic        clk,
    input  logic        ptr_rst,
    input  logic        en,
    input  logic [15:0] baud_div,
    input  logic        rx,
    output logic [7:0]  rx_data,
    output logic        byte_valid,
    output logic        frame_err
);
    import uart_dma_pkg::*;

    localparam int OS_W = $clog2(`UART_DMA_OVERSAMPLE);
    localparam logic [OS_W-1:0] OS_LAST = OS_W'(`UART_DMA_OVERSAMPLE - 1);
    localparam logic [OS_W-1:0] OS_MID = OS_W'(`UART_DMA_OVERSAMPLE / 2 - 1);

    logic [15:0]     baud_cnt;
    logic            tick;
    logic            rx_meta;
    logic            rx_sync;
    rx_bit_state_t   state;
    logic [OS_W-1:0] os_cnt;
    logic [2:0]      bit_cnt;
    logic [7:0]      shift_reg;
    logic            stop_sample;

    assign tick = en && (baud_cnt >= baud_div); // one tick every baud_div+1 clocks.

    always_ff @(posedge clk) begin
        if (ptr_rst || !en || tick) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (ptr_rst) begin
            rx_meta <= 1'b1; // the idle line is high.
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (ptr_rst || !en) begin
            state   <= RX_IDLE;
            os_cnt  <= '0;
            bit_cnt <= '0;
        end else if (tick) begin
            case (state)
                RX_IDLE: begin
                    os_cnt <= '0;
                    if (!rx_sync) state <= RX_START;
                end
                RX_START: begin
                    if (os_cnt == OS_MID) begin
                        os_cnt  <= '0;
                        bit_cnt <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA; // a glitch goes back to idle.
                    end else begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (os_cnt == OS_LAST) begin
                        os_cnt  <= '0;
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) state <= RX_STOP;
                    end else begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (os_cnt == OS_LAST) begin
                        os_cnt <= '0;
                        state  <= RX_IDLE;
                    end else begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tick && (state == RX_DATA) && (os_cnt == OS_LAST)) begin
            shift_reg <= {rx_sync, shift_reg[7:1]}; // lsb arrives first.
        end
    end

    assign stop_sample = (state == RX_STOP) && tick && (os_cnt == OS_LAST);
    assign byte_valid  = stop_sample && rx_sync;
    assign frame_err   = stop_sample && !rx_sync;
    assign rx_data     = shift_reg;

endmodule

/* design/uart_dma_pkg.sv */
package uart_dma_pkg;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_bit_state_t;

    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_DATA_READY,
        DMA_MEM_WAITING,
        DMA_MEM_DONE
    } dma_state_t;

    typedef enum logic [2:0] {
        SEL_CTRL,
        SEL_BAUD,
        SEL_BUF_START,
        SEL_BUF_END,
        SEL_PTR,
        SEL_STATUS,
        SEL_NONE // any offset outside the register map.
    } reg_sel_t;

endpackage

/* include/uart_dma_defines.svh */
`ifndef UART_DMA_DEFINES_SVH
`define UART_DMA_DEFINES_SVH

`define UART_DMA_AW 32
`define UART_DMA_DW 32

// baud ticks per bit on the serial line.
`define UART_DMA_OVERSAMPLE 8

// must stay a power of two.
`define UART_DMA_FIFO_DEPTH 8

`define UART_DMA_REG_CTRL      32'h0000_0000
`define UART_DMA_REG_BAUD      32'h0000_0004
`define UART_DMA_REG_BUF_START 32'h0000_0008
`define UART_DMA_REG_BUF_END   32'h0000_000C
`define UART_DMA_REG_PTR       32'h0000_0010
`define UART_DMA_REG_STATUS    32'h0000_0014

`endif
